// ==== src/clkdiv_pkg.sv ====
// ------------------------------
// shared definitions for the integer-N clock divider
//   ratio width and ratio type
//   divider mode encoding
//   ratio value loaded by reset
// ------------------------------

package clkdiv_pkg;

    // bits of the division ratio, ratios 0..7
    localparam int div_width_c = 3;

    // one ratio word
    typedef logic [div_width_c-1:0] div_ratio_t;

    // which divider drives the output
    typedef enum logic [1:0] {
        mode_bypass,    // ratio 0 or 1, input clock straight through
        mode_even,      // rising-edge counter only
        mode_odd        // dual-edge counters, xor combined
    } div_mode_e;

    // divide-by-2 out of reset
    localparam div_ratio_t ratio_reset_c = div_ratio_t'(2);

endpackage

// ==== src/div_ctrl_if.sv ====
// ------------------------------
// divider control bundle
//   synchronized ratio, precomputed half ratio,
//   odd calibration preload and decoded mode
//   one driver, three sink views
// ------------------------------

`timescale 1ns/1ps

interface div_ctrl_if;
    import clkdiv_pkg::*;

    div_ratio_t ratio;      // ratio after the 2-flop synchronizer
    div_ratio_t half_ratio; // ratio >> 1, even reload value
    div_ratio_t odd_offset; // (ratio+3)/2, falling counter wait
    div_mode_e  mode;       // decoded divider select

    // written by the synchronizer only
    modport src (output ratio, half_ratio, odd_offset, mode);

    modport even_sink (input half_ratio, mode);

    modport odd_sink (input ratio, odd_offset, mode);

    // output mux only cares which clock to pick
    modport out_sink (input mode);

endinterface

// ==== src/div_ratio_sync.sv ====
// ------------------------------
// ratio synchronizer and mode decode
//   two flops clocked by the divided clock
//   bypass / even / odd decode
//   half ratio and odd offset arithmetic
// ------------------------------

`timescale 1ns/1ps

module div_ratio_sync (
    input  logic                  clk_div,  // fed back from the output mux
    input  logic                  resetb,
    input  clkdiv_pkg::div_ratio_t ratio,   // async level from outside
    div_ctrl_if.src               ctrl
);
    import clkdiv_pkg::*;

    div_ratio_t ratio_meta;   // first stage, may go metastable
    div_ratio_t ratio_sync;   // second stage, safe to decode

    // one extra bit so ratio 7 + 3 does not wrap
    logic [div_width_c:0] offset_sum;

    // 2-flop synchronizer on the output clock domain
    always_ff @(posedge clk_div or negedge resetb) begin
        if (!resetb) begin
            ratio_meta <= ratio_reset_c;   // divide-by-2 default
            ratio_sync <= ratio_reset_c;
        end else begin
            ratio_meta <= ratio;
            ratio_sync <= ratio_meta;
        end
    end

    assign offset_sum = {1'b0, ratio_sync} + (div_width_c+1)'(3);

    assign ctrl.ratio      = ratio_sync;
    assign ctrl.half_ratio = ratio_sync >> 1;                // even reload
    assign ctrl.odd_offset = offset_sum[div_width_c:1];      // (ratio+3)/2

    // mode decode
    // 0 and 1 bypass, bit 0 low even, rest odd
    always_comb begin
        if (ratio_sync < div_ratio_t'(2)) begin
            ctrl.mode = mode_bypass;
        end else if (!ratio_sync[0]) begin
            ctrl.mode = mode_even;
        end else begin
            ctrl.mode = mode_odd;
        end
    end

    // odd mode only with an odd ratio
    a_odd_needs_odd_ratio : assert property (
        @(posedge clk_div) disable iff (!resetb)
        (ctrl.mode == mode_odd) |-> ctrl.ratio[0]
    ) else $error("odd mode with even ratio %0d", ctrl.ratio);

endmodule

// ==== src/even_div.sv ====
// ------------------------------
// even ratio divider
//   rising-edge down-counter
//   toggles clk_even every half_ratio edges
// ------------------------------

`timescale 1ns/1ps

module even_div (
    input  logic         clk,
    input  logic         resetb,
    div_ctrl_if.even_sink ctrl,
    output logic         clk_even
);
    import clkdiv_pkg::*;

    div_ratio_t cnt;       // edges left until the next toggle
    logic       enable;    // counter idles outside even mode

    assign enable = (ctrl.mode == mode_even);

    // counts 1 at reset so the first edge toggles
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            cnt      <= div_ratio_t'(1);
            clk_even <= 1'b1;             // output starts high
        end else if (enable) begin        // no switching when unused
            if (cnt <= div_ratio_t'(1)) begin
                cnt      <= ctrl.half_ratio;   // reload for next half period
                clk_even <= ~clk_even;
            end else begin
                cnt <= cnt - 1'b1;             // wait for bottom of interval
            end
        end
    end

    // a zero reload would stall the toggle
    // half_ratio comes from the synchronizer in the other clock domain
    a_half_ratio_nonzero : assert property (
        @(posedge clk) disable iff (!resetb)
        (ctrl.mode == mode_even) |-> (ctrl.half_ratio != '0)
    ) else $error("even mode with zero half ratio");

endmodule

// ==== src/odd_div.sv ====
// ------------------------------
// odd ratio divider, 50% duty
//   rising-edge counter and toggle flop
//   falling-edge counter with calibration wait
//   restart pulse on a ratio change
//   xor of both toggle flops
// ------------------------------

`timescale 1ns/1ps

module odd_div (
    input  logic        clk,
    input  logic        resetb,
    div_ctrl_if.odd_sink ctrl,
    output logic        clk_odd
);
    import clkdiv_pkg::*;

    div_ratio_t cnt_rise;     // posedge interval counter
    div_ratio_t cnt_fall;     // negedge interval counter
    div_ratio_t cal_fall;     // negedge edges still to skip
    logic       tgl_rise;     // toggles every ratio posedges
    logic       tgl_fall;     // toggles every ratio negedges
    div_ratio_t ratio_prev;   // ratio seen one clk earlier
    logic       restart;      // one-cycle reload pulse
    logic       enable;

    assign enable = (ctrl.mode == mode_odd);

    // the two flops toggle half an input cycle apart
    // so the xor changes every ratio/2 input cycles
    assign clk_odd = tgl_rise ^ tgl_fall;

    // change detect
    // also catches an even to odd move since ratio_prev is always updated
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            ratio_prev <= ratio_reset_c;
            restart    <= 1'b0;
        end else begin
            ratio_prev <= ctrl.ratio;
            restart    <= enable && (ctrl.ratio != ratio_prev);
        end
    end

    // rising side
    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            cnt_rise <= div_ratio_t'(1);
            tgl_rise <= 1'b1;
        end else if (restart) begin
            cnt_rise <= ctrl.ratio;           // start a fresh interval
            tgl_rise <= 1'b1;
        end else if (enable) begin
            if (cnt_rise <= div_ratio_t'(1)) begin
                cnt_rise <= ctrl.ratio;
                tgl_rise <= ~tgl_rise;
            end else begin
                cnt_rise <= cnt_rise - 1'b1;
            end
        end
    end

    // falling side
    // skips odd_offset edges first, then counts like the rising side
    always_ff @(negedge clk or negedge resetb) begin
        if (!resetb) begin
            cnt_fall <= div_ratio_t'(1);
            cal_fall <= '0;
            tgl_fall <= 1'b1;
        end else if (restart) begin
            cnt_fall <= ctrl.ratio;
            cal_fall <= ctrl.odd_offset;      // calibration preload
            tgl_fall <= 1'b1;
        end else if (enable) begin
            if (cal_fall > div_ratio_t'(1)) begin
                cal_fall <= cal_fall - 1'b1;  // still offsetting
            end else if (cnt_fall <= div_ratio_t'(1)) begin
                cnt_fall <= ctrl.ratio;
                tgl_fall <= ~tgl_fall;
            end else begin
                cnt_fall <= cnt_fall - 1'b1;
            end
        end
    end

    // a held ratio must not keep restarting the counters
    a_restart_single : assert property (
        @(posedge clk) disable iff (!resetb)
        (restart && $stable(ctrl.ratio)) |=> !restart
    ) else $error("odd restart pulse held with stable ratio %0d", ctrl.ratio);

endmodule

// ==== src/clk_out_select.sv ====
// ------------------------------
// output clock select
//   and-or combination of bypass,
//   even and odd clocks per mode
// ------------------------------

`timescale 1ns/1ps

module clk_out_select (
    input  logic        clk,        // bypass source
    div_ctrl_if.out_sink ctrl,
    input  logic        clk_even,
    input  logic        clk_odd,
    output logic        clk_div
);
    import clkdiv_pkg::*;

    logic sel_bypass;   // one-hot selects
    logic sel_even;
    logic sel_odd;

    assign sel_bypass = (ctrl.mode == mode_bypass);
    assign sel_even   = (ctrl.mode == mode_even);
    assign sel_odd    = (ctrl.mode == mode_odd);

    // and-or mux, no select ever passes two clocks at once
    assign clk_div = (clk      & sel_bypass)
                   | (clk_even & sel_even)
                   | (clk_odd  & sel_odd);

    // the fourth encoding would leave clk_div stuck low
    // and stop the synchronizer that feeds the mode back
    a_mode_legal : assert property (
        @(posedge clk)
        ctrl.mode inside {mode_bypass, mode_even, mode_odd}
    ) else $error("illegal divider mode %b", ctrl.mode);

endmodule

// ==== src/clock_div.sv ====
// ------------------------------
// programmable integer-N clock divider, top level
//   ratio synchronizer and decode
//   even and odd dividers
//   output clock select
// ------------------------------

`timescale 1ns/1ps

module clock_div (
    input  logic                  clk,      // fast input clock
    input  logic                  resetb,   // async, active low
    input  clkdiv_pkg::div_ratio_t ratio,   // divide value, plain level
    output logic                  clk_div   // divided clock
);

    logic clk_even;   // even divider output
    logic clk_odd;    // odd divider output

    div_ctrl_if ctrl_if ();

    // clocked by its own output
    div_ratio_sync sync0 (
        .clk_div (clk_div),
        .resetb  (resetb),
        .ratio   (ratio),
        .ctrl    (ctrl_if.src)
    );

    even_div even0 (
        .clk      (clk),
        .resetb   (resetb),
        .ctrl     (ctrl_if.even_sink),
        .clk_even (clk_even)
    );

    odd_div odd0 (
        .clk     (clk),
        .resetb  (resetb),
        .ctrl    (ctrl_if.odd_sink),
        .clk_odd (clk_odd)
    );

    clk_out_select sel0 (
        .clk      (clk),
        .ctrl     (ctrl_if.out_sink),
        .clk_even (clk_even),
        .clk_odd  (clk_odd),
        .clk_div  (clk_div)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
// ------------------------------
// testbench clock and reset source
//   8 ns input clock, 50% duty
//   power-on reset low for 3 cycles
// ------------------------------

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic resetb     // power-on reset, active low
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;        // half of the 8 ns period
    end

    initial begin
        resetb = 1'b0;
        repeat (3) @(posedge clk);    // three full cycles in reset
        resetb <= 1'b1;
    end

endmodule

// ==== test/clock_div_tb.sv ====
// ------------------------------
// clock divider testbench
//   directed even, odd and bypass ratios
//   30 random ratio changes, fixed seed
//   period and high time model, 1 ns window
//   mid-run reset, watchdog, summary
// ------------------------------

`timescale 1ns/1ps

module clock_div_tb;
    import clkdiv_pkg::*;

    localparam int  num_tests_c   = 40;     // 1 + 3 + 3 + 2 + 30 + 1
    localparam int  num_random_c  = 30;
    localparam real tol_ns_c      = 1.0;    // allowed edge error
    // 40 tests x 20 periods of the slowest ratio (7 x 8 ns)
    localparam real watchdog_ns_c = num_tests_c * 20 * 7 * 8.0;

    logic       clk;
    logic       por_resetb;     // from the clock generator
    logic       mid_resetb;     // driven by the test sequence
    logic       resetb;
    div_ratio_t ratio;
    logic       clk_div;

    div_ratio_t cur_ratio;      // ratio the DUT is expected to run at
    int         seed;
    int         test_num;
    int         pass_count;
    int         fail_count;

    assign resetb = por_resetb & mid_resetb;

    tb_clk_gen clk_gen0 (
        .clk    (clk),
        .resetb (por_resetb)
    );

    clock_div dut0 (
        .clk     (clk),
        .resetb  (resetb),
        .ratio   (ratio),
        .clk_div (clk_div)
    );

    // output period in ns for a ratio
    function automatic real expected_period(input div_ratio_t r);
        if (r < div_ratio_t'(2)) begin
            return 8.0;             // bypass follows the input clock
        end else begin
            return 8.0 * r;
        end
    endfunction

    // 50% duty for every ratio
    function automatic real expected_high(input div_ratio_t r);
        return expected_period(r) / 2.0;
    endfunction

    // true when measured is outside the window around expected
    function automatic bit off_window(input real measured, input real expected);
        return (measured - expected > tol_ns_c) || (expected - measured > tol_ns_c);
    endfunction

    // one error line for a time outside the window
    task automatic report_bad_time(input string name, input div_ratio_t r, input string what,
                                   input real exp_ns, input real got_ns);
        $display("MISMATCH at %0t ns: %s ratio %0d %s expected %0.1f ns measured %0.1f ns",
                 $time, name, r, what, exp_ns, got_ns);
    endtask

    // drive a new ratio, then wait 4 old plus 2 new periods to settle
    task automatic apply_ratio(input div_ratio_t r);
        real settle_ns;
        begin
            settle_ns = 4.0 * expected_period(cur_ratio) + 2.0 * expected_period(r);
            @(posedge clk);
            ratio <= r;
            #(settle_ns);
            cur_ratio = r;
        end
    endtask

    // timestamp edges of clk_div over three periods and compare
    // rise_by bounds the first rising edge, 0 leaves it open
    task automatic measure_ratio(input string name, input div_ratio_t r, input real rise_by);
        real t_rise;
        real t_fall;
        real t_next;
        real exp_per;
        real exp_high;
        real per;
        real high;
        int  errs;
        int  i;
        begin
            errs     = 0;
            exp_per  = expected_period(r);
            exp_high = expected_high(r);
            test_num = test_num + 1;
            @(posedge clk_div);
            t_rise = $realtime;
            if (rise_by > 0.0 && t_rise > rise_by) begin
                $display("clk_div first rise late at %0t ns, %s test wanted it by %0.1f ns",
                         $time, name, rise_by);
                errs = errs + 1;
            end
            for (i = 0; i < 3; i++) begin
                @(negedge clk_div);
                t_fall = $realtime;
                @(posedge clk_div);
                t_next = $realtime;
                per    = t_next - t_rise;
                high   = t_fall - t_rise;
                if (off_window(per, exp_per)) begin
                    report_bad_time(name, r, "period", exp_per, per);
                    errs = errs + 1;
                end
                if (off_window(high, exp_high)) begin
                    report_bad_time(name, r, "high", exp_high, high);
                    errs = errs + 1;
                end
                t_rise = t_next;    // next period starts here
            end
            if (errs == 0) begin
                pass_count = pass_count + 1;
                $display("test %0d %s ratio %0d: period %0.1f ns high %0.1f ns ok",
                         test_num, name, r, per, high);
            end else begin
                fail_count = fail_count + 1;
                $display("test %0d %s ratio %0d: %0d wrong measurements",
                         test_num, name, r, errs);
            end
        end
    endtask

    task automatic run_ratio(input string name, input div_ratio_t r);
        apply_ratio(r);
        measure_ratio(name, r, 0.0);
    endtask

    initial begin
        int         i;
        div_ratio_t r;
        ratio      = ratio_reset_c;   // same as the reset default
        mid_resetb = 1'b1;
        seed       = 88116;
        cur_ratio  = ratio_reset_c;
        test_num   = 0;
        pass_count = 0;
        fail_count = 0;

        // default divide-by-2, ratio never touched
        wait (resetb === 1'b1);
        #(6.0 * expected_period(ratio_reset_c));
        measure_ratio("default", ratio_reset_c, 0.0);

        // even ratios, single counter
        run_ratio("even", div_ratio_t'(2));
        run_ratio("even", div_ratio_t'(4));
        run_ratio("even", div_ratio_t'(6));

        // odd ratios, dual-edge duty fix
        run_ratio("odd", div_ratio_t'(3));
        run_ratio("odd", div_ratio_t'(5));
        run_ratio("odd", div_ratio_t'(7));

        run_ratio("bypass", div_ratio_t'(0));
        run_ratio("bypass", div_ratio_t'(1));

        // random walk, two forced odd draws out of four
        // so odd to odd and even to odd moves both show up
        for (i = 0; i < num_random_c; i++) begin
            r = div_ratio_t'($random(seed));
            if (i % 4 == 1 || i % 4 == 2) begin
                r[0] = 1'b1;
                if (r == div_ratio_t'(1)) begin
                    r = div_ratio_t'(3);    // keep it out of bypass
                end
            end
            run_ratio("random", r);
        end

        // reset while dividing by 7, ratio held at 2 from then on
        // divide-by-2 expected within one period of release
        // the 56 ns clock is far too slow to sync the new ratio by then
        apply_ratio(div_ratio_t'(7));
        @(posedge clk);
        mid_resetb <= 1'b0;
        ratio      <= ratio_reset_c;
        repeat (3) @(posedge clk);
        mid_resetb <= 1'b1;
        cur_ratio = ratio_reset_c;
        measure_ratio("mid reset", ratio_reset_c,
                      $realtime + expected_period(ratio_reset_c) + tol_ns_c);

        $display("tests %0d, passed %0d, failed %0d", test_num, pass_count, fail_count);
        if (fail_count == 0 && test_num == num_tests_c) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // stuck clk_div or a runaway sequence
    initial begin
        #(watchdog_ns_c);
        $display("simulation timed out after %0.0f ns, clk_div stopped or tests ran too long",
                 watchdog_ns_c);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/clkdiv_pkg.sv
src/div_ctrl_if.sv
src/div_ratio_sync.sv
src/even_div.sv
src/odd_div.sv
src/clk_out_select.sv
src/clock_div.sv
test/tb_clk_gen.sv
test/clock_div_tb.sv
